// File: source/shell_pkg.sv
// Shell package
// Host download indices, address and data types shared by the download,
// reset and status blocks of the TRS-80 shell

package shell_pkg;

	// ========================================================================
	// Widths
	// ========================================================================

	// Host download byte address and CPU address space
	localparam int IOCTL_AW = 16;
	// Main RAM adds one bit on top for the cassette image half
	localparam int RAM_AW   = IOCTL_AW + 1;
	localparam int BYTE_W   = 8;

	// ========================================================================
	// Types
	// ========================================================================

	// Download target selected by the host menu entry
	typedef enum logic [7:0] {
		idx_rom      = 8'h00,
		idx_cassette = 8'h01,
		idx_cmd      = 8'h02,
		idx_snapshot = 8'h03,
		idx_omikron  = 8'h40
	} ioctl_index_e;

	typedef logic [IOCTL_AW-1:0] ioctl_addr_t;
	typedef logic [RAM_AW-1:0]   ram_addr_t;
	typedef logic [BYTE_W-1:0]   byte_t;

	// Program entry point reported by the core
	typedef logic [IOCTL_AW-1:0] exec_addr_t;

endpackage

// File: source/mt32_pkg.sv
// MT32-pi package
// Synth modes, audio sample types and info message codes

package mt32_pkg;

	// Mode byte reported by the MT32-pi
	typedef enum logic [7:0] {
		mode_munt  = 8'hA1,
		mode_fluid = 8'hA2
	} mt32_mode_e;

	typedef logic signed [15:0] sample_t;
	// Unsigned beeper level from the core
	typedef logic [8:0]         beep_level_t;
	typedef logic [7:0]         info_code_t;

	// Info message indices
	// SoundFont messages start at 1, one per SoundFont 0 to 7
	localparam info_code_t INFO_SF_BASE  = 8'd1;
	localparam info_code_t INFO_MT32_V1  = 8'd9;
	localparam info_code_t INFO_MT32_V2  = 8'd10;
	localparam info_code_t INFO_CM32L    = 8'd11;
	localparam info_code_t INFO_UNKNOWN  = 8'd12;

endpackage

// File: source/ioctl_if.sv
// Host download interface
// One byte per cycle in which wr is high during a download, never refused

`timescale 1ns/1ps

interface ioctl_if import shell_pkg::*; ();

	logic         download;
	logic         wr;
	ioctl_addr_t  addr;
	byte_t        data;
	ioctl_index_e index;

	modport sink (
		input download,
		input wr,
		input addr,
		input data,
		input index
	);

endinterface

// File: source/mt32_if.sv
// MT32-pi status interface
// Mode, ROM and SoundFont selection plus the synth sample stream

`timescale 1ns/1ps

interface mt32_if import mt32_pkg::*; ();

	mt32_mode_e mode;
	logic [7:0] rom;
	logic [7:0] sf;
	logic       newmode;
	logic       available;
	// High when the user turned the MT32-pi off in the menu
	logic       disabled;
	sample_t    sample;

	modport sink (
		input mode,
		input rom,
		input sf,
		input newmode,
		input available,
		input disabled,
		input sample
	);

endinterface

// File: source/download_router.sv
// Download router
// Steers host downloads to main RAM or the Omikron ROM buffer and
// clears the menu-hidden state on snapshot writes

`timescale 1ns/1ps

module download_router import shell_pkg::*; #(
	parameter int OMKR_ROM_AW = 11
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	ioctl_if.sink                  dl,
	output logic                   ram_wr,
	output ram_addr_t              ram_addr,
	output byte_t                  ram_data,
	input  logic [OMKR_ROM_AW-1:0] omkr_addr,
	output byte_t                  omkr_data,
	output logic                   state_menu_hidden
);

	logic  accept;
	logic  ram_we;
	logic  omkr_we;
	logic  snap_odd;
	byte_t omkr_mem [2**OMKR_ROM_AW];

	assign accept   = dl.download && dl.wr;
	// Only ROM and cassette images land in main RAM
	assign ram_we   = accept && (dl.index == idx_rom || dl.index == idx_cassette);
	assign omkr_we  = accept && (dl.index == idx_omikron);
	assign snap_odd = accept && (dl.index == idx_snapshot) && dl.addr[0];

	// ========================================================================
	// Main RAM write path
	// ========================================================================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ram_wr <= 1'b0;
		end else begin
			ram_wr <= ram_we;
		end
	end

	// Cassette images sit in the upper 64K
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram_addr <= {dl.index != idx_rom, dl.addr};
			ram_data <= dl.data;
		end
	end

	// ========================================================================
	// Omikron ROM buffer
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (omkr_we) begin
			omkr_mem[dl.addr[OMKR_ROM_AW-1:0]] <= dl.data;
		end
	end

	// Read port for the core mapper
	always_ff @(posedge clk_sys) begin
		omkr_data <= omkr_mem[omkr_addr];
	end

	// Menu stays hidden until a snapshot has been written
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state_menu_hidden <= 1'b1;
		end else if (snap_odd) begin
			state_menu_hidden <= 1'b0;
		end
	end

	a_single_target: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(ram_we && omkr_we)
	) else $error("RAM and Omikron buffer written in the same cycle");

endmodule

// File: source/reset_control.sv
// Reset control
// Combines the reset sources and stretches a mapper reset pulse
// whenever the Omikron CP/M switch changes

`timescale 1ns/1ps

module reset_control import shell_pkg::*; #(
	parameter int OMKR_PULSE_CYCLES = 15
) (
	input  logic  clk_sys,
	input  logic  reset,
	ioctl_if.sink dl,
	input  logic  osd_reset,
	input  logic  user_button,
	input  logic  omikron_sel,
	output logic  sys_reset,
	output logic  mapper_reset
);

	localparam int CNT_W = $clog2(OMKR_PULSE_CYCLES + 1);

	logic             omikron_prev;
	logic             toggle;
	logic [CNT_W-1:0] pulse_cnt;
	logic             rom_download;

	// Tracks the switch through reset so that release gives no false toggle
	always_ff @(posedge clk_sys) begin
		omikron_prev <= omikron_sel;
	end

	assign toggle = omikron_sel != omikron_prev;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			pulse_cnt <= '0;
		end else if (toggle) begin
			pulse_cnt <= CNT_W'(OMKR_PULSE_CYCLES);
		end else if (pulse_cnt != '0) begin
			pulse_cnt <= pulse_cnt - 1'b1;
		end
	end

	assign rom_download = dl.download && (dl.index == idx_rom);

	// Mapper reset holds the core while a new ROM streams in
	assign mapper_reset = reset || rom_download || (pulse_cnt != '0);
	assign sys_reset    = mapper_reset || osd_reset || user_button;

	a_omkr_stretch: assert property (
		@(posedge clk_sys) disable iff (reset)
		toggle |=> mapper_reset [*OMKR_PULSE_CYCLES]
	) else $error("Omikron mapper reset shorter than expected");

endmodule

// File: source/osd_status_tracker.sv
// OSD status tracker
// Selects which debug line the status overlay shows

`timescale 1ns/1ps

module osd_status_tracker import shell_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       debug_view,
	input  exec_addr_t execute_addr,
	output logic       debug_line
);

	logic       view_prev;
	exec_addr_t addr_prev;
	logic       view_fall;
	logic       addr_change;

	// Follows the address through reset so release is quiet
	always_ff @(posedge clk_sys) begin
		addr_prev <= execute_addr;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			view_prev <= 1'b0;
		end else begin
			view_prev <= debug_view;
		end
	end

	assign view_fall   = view_prev && !debug_view;
	assign addr_change = execute_addr != addr_prev;

	// A new execute address always brings its line into view
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			debug_line <= 1'b0;
		end else if (addr_change) begin
			debug_line <= 1'b1;
		end else if (view_fall) begin
			debug_line <= !debug_line;
		end
	end

endmodule

// File: source/audio_mixer.sv
// Audio mixer
// Adds the core beeper level to the MT32-pi sample and saturates
// the result to the signed 16-bit range, two pipeline stages

`timescale 1ns/1ps

module audio_mixer import mt32_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	mt32_if.sink        mt,
	input  beep_level_t beep_level,
	output sample_t     audio_out
);

	logic               mute;
	logic signed [17:0] beep_ext;
	logic signed [17:0] synth_ext;
	// One bit of headroom, a full beeper plus a loud sample exceeds 17 bits
	logic signed [17:0] sum;

	assign mute      = mt.available && mt.disabled;
	assign beep_ext  = {2'b00, beep_level, 7'b0000000};
	assign synth_ext = mute ? '0 : 18'(mt.sample);

	// Stage one adds
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			sum <= '0;
		end else begin
			sum <= beep_ext + synth_ext;
		end
	end

	// Stage two clamps when the top bits disagree
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			audio_out <= '0;
		end else if (sum[17:15] == 3'b000 || sum[17:15] == 3'b111) begin
			audio_out <= sum[15:0];
		end else begin
			audio_out <= sum[17] ? 16'sh8000 : 16'sh7fff;
		end
	end

	a_out_known: assert property (
		@(posedge clk_sys) disable iff (reset)
		!$isunknown(audio_out)
	) else $error("Audio output unknown");

endmodule

// File: source/mt32_info_encoder.sv
// MT32-pi info encoder
// Maps the synth mode to an info message and requests it on a mode change

`timescale 1ns/1ps

module mt32_info_encoder import mt32_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	mt32_if.sink       mt,
	input  logic [1:0] info_sel,
	output info_code_t info,
	output logic       info_req
);

	logic       newmode_prev;
	info_code_t code;

	always_comb begin
		case (mt.mode)
			mode_fluid: code = INFO_SF_BASE + info_code_t'(mt.sf[2:0]);
			mode_munt: begin
				case (mt.rom)
					8'd0:    code = INFO_MT32_V1;
					8'd1:    code = INFO_MT32_V2;
					8'd2:    code = INFO_CM32L;
					default: code = INFO_UNKNOWN;
				endcase
			end
			default: code = INFO_UNKNOWN;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		newmode_prev <= mt.newmode;
		info         <= code;
	end

	// Info setting 1 means show a message on each mode change
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			info_req <= 1'b0;
		end else begin
			info_req <= (newmode_prev != mt.newmode) && (info_sel == 2'd1);
		end
	end

endmodule

// File: source/trs80_shell.sv
// TRS-80 shell
// Housekeeping around the core: downloads, resets, status line,
// audio mix and MT32-pi info messages

`timescale 1ns/1ps

module trs80_shell import shell_pkg::*, mt32_pkg::*; #(
	parameter int OMKR_PULSE_CYCLES = 15,
	parameter int OMKR_ROM_AW       = 11
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	// Host download stream
	input  logic                   ioctl_download,
	input  logic                   ioctl_wr,
	input  ioctl_addr_t            ioctl_addr,
	input  byte_t                  ioctl_data,
	input  logic [7:0]             ioctl_index,
	// Main RAM and Omikron buffer
	output logic                   ram_wr,
	output ram_addr_t              ram_addr,
	output byte_t                  ram_data,
	input  logic [OMKR_ROM_AW-1:0] omkr_addr,
	output byte_t                  omkr_data,
	output logic                   state_menu_hidden,
	// Resets
	input  logic                   osd_reset,
	input  logic                   user_button,
	input  logic                   omikron_sel,
	output logic                   sys_reset,
	output logic                   mapper_reset,
	// Status line
	input  logic                   debug_view,
	input  exec_addr_t             execute_addr,
	output logic                   debug_line,
	// MT32-pi and audio
	input  logic [7:0]             mt32_mode,
	input  logic [7:0]             mt32_rom,
	input  logic [7:0]             mt32_sf,
	input  logic                   mt32_newmode,
	input  logic                   mt32_available,
	input  logic                   mt32_disable,
	input  sample_t                mt32_sample,
	input  beep_level_t            beep_level,
	output sample_t                audio_out,
	input  logic [1:0]             info_sel,
	output info_code_t             info,
	output logic                   info_req
);

	ioctl_if dl ();
	mt32_if  mt ();

	assign dl.download = ioctl_download;
	assign dl.wr       = ioctl_wr;
	assign dl.addr     = ioctl_addr;
	assign dl.data     = ioctl_data;
	assign dl.index    = ioctl_index_e'(ioctl_index);

	assign mt.mode      = mt32_mode_e'(mt32_mode);
	assign mt.rom       = mt32_rom;
	assign mt.sf        = mt32_sf;
	assign mt.newmode   = mt32_newmode;
	assign mt.available = mt32_available;
	assign mt.disabled  = mt32_disable;
	assign mt.sample    = mt32_sample;

	download_router #(
		.OMKR_ROM_AW (OMKR_ROM_AW)
	) u_download_router (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.dl                (dl),
		.ram_wr            (ram_wr),
		.ram_addr          (ram_addr),
		.ram_data          (ram_data),
		.omkr_addr         (omkr_addr),
		.omkr_data         (omkr_data),
		.state_menu_hidden (state_menu_hidden)
	);

	reset_control #(
		.OMKR_PULSE_CYCLES (OMKR_PULSE_CYCLES)
	) u_reset_control (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl           (dl),
		.osd_reset    (osd_reset),
		.user_button  (user_button),
		.omikron_sel  (omikron_sel),
		.sys_reset    (sys_reset),
		.mapper_reset (mapper_reset)
	);

	osd_status_tracker u_osd_status_tracker (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.debug_view   (debug_view),
		.execute_addr (execute_addr),
		.debug_line   (debug_line)
	);

	audio_mixer u_audio_mixer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mt         (mt),
		.beep_level (beep_level),
		.audio_out  (audio_out)
	);

	mt32_info_encoder u_mt32_info_encoder (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mt       (mt),
		.info_sel (info_sel),
		.info     (info),
		.info_req (info_req)
	);

endmodule

// File: bench/trs80_shell_tb.sv
// TRS-80 shell testbench
// Replays the records of the test file against the shell and checks
// download routing, resets, status line, audio mix and MT32 info codes

`timescale 1ns/1ps

module trs80_shell_tb import shell_pkg::*, mt32_pkg::*; ();

	localparam int PULSE_CYCLES = 15;
	localparam int ROM_AW       = 11;

	logic              clk_sys;
	logic              reset;
	logic              ioctl_download;
	logic              ioctl_wr;
	ioctl_addr_t       ioctl_addr;
	byte_t             ioctl_data;
	logic [7:0]        ioctl_index;
	logic              ram_wr;
	ram_addr_t         ram_addr;
	byte_t             ram_data;
	logic [ROM_AW-1:0] omkr_addr;
	byte_t             omkr_data;
	logic              state_menu_hidden;
	logic              osd_reset;
	logic              user_button;
	logic              omikron_sel;
	logic              sys_reset;
	logic              mapper_reset;
	logic              debug_view;
	exec_addr_t        execute_addr;
	logic              debug_line;
	logic [7:0]        mt32_mode;
	logic [7:0]        mt32_rom;
	logic [7:0]        mt32_sf;
	logic              mt32_newmode;
	logic              mt32_available;
	logic              mt32_disable;
	sample_t           mt32_sample;
	beep_level_t       beep_level;
	sample_t           audio_out;
	logic [1:0]        info_sel;
	info_code_t        info;
	logic              info_req;

	integer fd;
	integer seed;
	int     test_errs;
	int     test_count;
	int     fail_count;

	// Bytes written to the Omikron buffer so far
	ioctl_addr_t omkr_addrs[$];
	byte_t       omkr_bytes[$];

	trs80_shell #(
		.OMKR_PULSE_CYCLES (PULSE_CYCLES),
		.OMKR_ROM_AW       (ROM_AW)
	) dut (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.ioctl_download    (ioctl_download),
		.ioctl_wr          (ioctl_wr),
		.ioctl_addr        (ioctl_addr),
		.ioctl_data        (ioctl_data),
		.ioctl_index       (ioctl_index),
		.ram_wr            (ram_wr),
		.ram_addr          (ram_addr),
		.ram_data          (ram_data),
		.omkr_addr         (omkr_addr),
		.omkr_data         (omkr_data),
		.state_menu_hidden (state_menu_hidden),
		.osd_reset         (osd_reset),
		.user_button       (user_button),
		.omikron_sel       (omikron_sel),
		.sys_reset         (sys_reset),
		.mapper_reset      (mapper_reset),
		.debug_view        (debug_view),
		.execute_addr      (execute_addr),
		.debug_line        (debug_line),
		.mt32_mode         (mt32_mode),
		.mt32_rom          (mt32_rom),
		.mt32_sf           (mt32_sf),
		.mt32_newmode      (mt32_newmode),
		.mt32_available    (mt32_available),
		.mt32_disable      (mt32_disable),
		.mt32_sample       (mt32_sample),
		.beep_level        (beep_level),
		.audio_out         (audio_out),
		.info_sel          (info_sel),
		.info              (info),
		.info_req          (info_req)
	);

	initial clk_sys = 1'b0;

	always #5 clk_sys = !clk_sys;

	// ========================================================================
	// Helpers
	// ========================================================================

	// Drive and sample point, 1 ns after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic mismatch(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		test_errs++;
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (test_errs == 0) begin
			$display("test %0d %s ok", test_count, name);
		end else begin
			$display("test %0d %s failed with %0d errors", test_count, name, test_errs);
			fail_count++;
		end
	endtask

	// Beeper shifted up by seven plus the sample, clamped to 16 bits signed
	function automatic sample_t clamp_mix(input beep_level_t beep, input sample_t smp,
			input logic mute);
		int total;
		total = int'(beep) * 128;
		if (!mute) begin
			total = total + int'(smp);
		end
		if (total > 32767) begin
			total = 32767;
		end else if (total < -32768) begin
			total = -32768;
		end
		return sample_t'(total);
	endfunction

	task automatic send_byte(input logic [7:0] idx, input ioctl_addr_t addr, input byte_t data);
		ioctl_index    = idx;
		ioctl_addr     = addr;
		ioctl_data     = data;
		ioctl_download = 1'b1;
		ioctl_wr       = 1'b1;
		tick();
		ioctl_wr       = 1'b0;
		ioctl_download = 1'b0;
	endtask

	// ========================================================================
	// Test cases
	// ========================================================================

	task automatic route_ram_write(input logic [7:0] idx, input ioctl_addr_t addr,
			input byte_t data, input logic exp_wr, input ram_addr_t exp_addr);
		int waited;
		waited = 0;
		send_byte(idx, addr, data);
		while (!ram_wr && waited < 4) begin
			tick();
			waited++;
		end
		if (exp_wr && !ram_wr) begin
			$display("no RAM write appeared within 4 cycles of the download byte");
			test_errs++;
		end else if (!exp_wr && ram_wr) begin
			mismatch($sformatf("RAM write for index %0d", idx));
		end else if (exp_wr) begin
			if (waited != 0) begin
				mismatch($sformatf("RAM write came %0d cycles late", waited));
			end
			if (ram_addr !== exp_addr) begin
				mismatch($sformatf("ram_addr %h, expected %h", ram_addr, exp_addr));
			end
			if (ram_data !== data) begin
				mismatch($sformatf("ram_data %h, expected %h", ram_data, data));
			end
		end
	endtask

	task automatic readback_omikron(input ioctl_addr_t addr, input byte_t data,
			input byte_t exp);
		int k;
		send_byte(8'h40, addr, data);
		omkr_addr = addr[ROM_AW-1:0];
		tick();
		if (omkr_data !== exp) begin
			mismatch($sformatf("omkr_data %h at %h, expected %h", omkr_data, addr, exp));
		end
		for (k = omkr_addrs.size() - 1; k >= 0; k--) begin
			if (omkr_addrs[k][ROM_AW-1:0] == addr[ROM_AW-1:0]) begin
				omkr_addrs.delete(k);
				omkr_bytes.delete(k);
			end
		end
		// Earlier bytes stay in place after writes to other locations
		for (k = 0; k < omkr_addrs.size(); k++) begin
			omkr_addr = omkr_addrs[k][ROM_AW-1:0];
			tick();
			if (omkr_data !== omkr_bytes[k]) begin
				mismatch($sformatf("omkr_data %h at %h, expected %h",
					omkr_data, omkr_addrs[k], omkr_bytes[k]));
			end
		end
		omkr_addrs.push_back(addr);
		omkr_bytes.push_back(exp);
	endtask

	task automatic time_mapper_pulse(input int exp_cycles);
		int waited;
		int high;
		waited = 0;
		high   = 0;
		if (mapper_reset) begin
			mismatch("mapper_reset high before the switch toggled");
		end
		omikron_sel = !omikron_sel;
		while (!mapper_reset && waited < 4) begin
			tick();
			waited++;
		end
		if (!mapper_reset) begin
			$display("mapper_reset did not rise after the Omikron switch toggled");
			test_errs++;
		end else begin
			if (waited != 1) begin
				mismatch($sformatf("mapper_reset rose after %0d cycles", waited));
			end
			while (mapper_reset && high < exp_cycles + 8) begin
				if (!sys_reset) begin
					mismatch("sys_reset low while mapper_reset is high");
				end
				high++;
				tick();
			end
			if (high != exp_cycles) begin
				mismatch($sformatf("mapper_reset high %0d cycles, expected %0d",
					high, exp_cycles));
			end
			if (sys_reset !== 1'b0) begin
				mismatch("sys_reset still high after mapper_reset fell");
			end
		end
	endtask

	task automatic exercise_debug_line(input logic kind, input exec_addr_t addr,
			input logic exp);
		if (kind) begin
			execute_addr = addr;
			tick();
		end else begin
			debug_view = 1'b1;
			tick();
			debug_view = 1'b0;
			tick();
		end
		if (debug_line !== exp) begin
			mismatch($sformatf("debug_line %b, expected %b", debug_line, exp));
		end
	endtask

	task automatic write_snapshot(input ioctl_addr_t addr, input logic exp_hidden);
		send_byte(8'h03, addr, 8'h00);
		if (state_menu_hidden !== exp_hidden) begin
			mismatch($sformatf("state_menu_hidden %b, expected %b",
				state_menu_hidden, exp_hidden));
		end
	endtask

	task automatic mix_single(input beep_level_t beep, input sample_t smp, input logic avail,
			input logic dis, input sample_t exp);
		beep_level     = beep;
		mt32_sample    = smp;
		mt32_available = avail;
		mt32_disable   = dis;
		tick();
		tick();
		if (audio_out !== exp) begin
			mismatch($sformatf("audio_out %h, expected %h", audio_out, exp));
		end
	endtask

	// New sample every cycle so that two are in flight in the mixer
	task automatic stream_random_audio(input int count);
		sample_t     expected[$];
		sample_t     want;
		logic [31:0] r;
		int          k;
		for (k = 0; k < count + 2; k++) begin
			if (k >= 2) begin
				want = expected.pop_front();
				if (audio_out !== want) begin
					mismatch($sformatf("audio_out %h, expected %h", audio_out, want));
				end
			end
			if (k < count) begin
				r              = $random(seed);
				beep_level     = r[8:0];
				mt32_available = r[30];
				mt32_disable   = r[31];
				r              = $random(seed);
				mt32_sample    = r[15:0];
				expected.push_back(clamp_mix(beep_level, mt32_sample,
					mt32_available && mt32_disable));
			end
			tick();
		end
	endtask

	task automatic encode_info(input logic [7:0] mode, input logic [7:0] rom,
			input logic [7:0] sf, input info_code_t exp);
		mt32_mode = mode;
		mt32_rom  = rom;
		mt32_sf   = sf;
		tick();
		if (info !== exp) begin
			mismatch($sformatf("info %0d for mode %h rom %0d, expected %0d",
				info, mode, rom, exp));
		end
	endtask

	task automatic pulse_newmode(input logic [1:0] sel, input int exp_pulses);
		int k;
		int pulses;
		int first;
		pulses       = 0;
		first        = 0;
		info_sel     = sel;
		mt32_newmode = !mt32_newmode;
		for (k = 1; k <= 4; k++) begin
			tick();
			if (info_req) begin
				pulses++;
				if (first == 0) begin
					first = k;
				end
			end
		end
		if (pulses != exp_pulses) begin
			mismatch($sformatf("info_req pulsed %0d cycles, expected %0d", pulses, exp_pulses));
		end else if (pulses != 0 && first > 2) begin
			mismatch($sformatf("info_req came %0d cycles after the toggle", first));
		end
	endtask

	// ========================================================================
	// File replay
	// ========================================================================

	task automatic replay_file();
		int               code;
		logic [8*8-1:0]   tok;
		logic [8*200-1:0] rest;
		logic [31:0]      v0;
		logic [31:0]      v1;
		logic [31:0]      v2;
		logic [31:0]      v3;
		logic [31:0]      v4;
		code = $fscanf(fd, "%s", tok);
		while (code == 1) begin
			test_errs = 0;
			case (tok[7:0])
				"#": code = $fgets(rest, fd);
				"R": begin
					code = $fscanf(fd, "%h %h %h %h %h", v0, v1, v2, v3, v4);
					route_ram_write(v0[7:0], v1[15:0], v2[7:0], v3[0], v4[16:0]);
					finish_test("download routing");
				end
				"O": begin
					code = $fscanf(fd, "%h %h %h", v0, v1, v2);
					readback_omikron(v0[15:0], v1[7:0], v2[7:0]);
					finish_test("Omikron buffer");
				end
				"M": begin
					code = $fscanf(fd, "%h", v0);
					time_mapper_pulse(v0);
					finish_test("mapper reset pulse");
				end
				"D": begin
					code = $fscanf(fd, "%h %h %h", v0, v1, v2);
					exercise_debug_line(v0[0], v1[15:0], v2[0]);
					finish_test("debug line");
				end
				"S": begin
					code = $fscanf(fd, "%h %h", v0, v1);
					write_snapshot(v0[15:0], v1[0]);
					finish_test("snapshot");
				end
				"A": begin
					code = $fscanf(fd, "%h %h %h %h %h", v0, v1, v2, v3, v4);
					mix_single(v0[8:0], v1[15:0], v2[0], v3[0], v4[15:0]);
					finish_test("audio mix");
				end
				"X": begin
					code = $fscanf(fd, "%h", v0);
					stream_random_audio(v0);
					finish_test("random audio");
				end
				"I": begin
					code = $fscanf(fd, "%h %h %h %h", v0, v1, v2, v3);
					encode_info(v0[7:0], v1[7:0], v2[7:0], v3[7:0]);
					finish_test("info code");
				end
				"N": begin
					code = $fscanf(fd, "%h %h", v0, v1);
					pulse_newmode(v0[1:0], v1);
					finish_test("info request");
				end
				default: begin
					$display("unknown record letter in the test file");
					test_errs++;
					finish_test("bad record");
				end
			endcase
			code = $fscanf(fd, "%s", tok);
		end
	endtask

	initial begin
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		ioctl_index    = '0;
		omkr_addr      = '0;
		osd_reset      = 1'b0;
		user_button    = 1'b0;
		omikron_sel    = 1'b0;
		debug_view     = 1'b0;
		execute_addr   = '0;
		mt32_mode      = 8'hA1;
		mt32_rom       = '0;
		mt32_sf        = '0;
		mt32_newmode   = 1'b0;
		mt32_available = 1'b0;
		mt32_disable   = 1'b0;
		mt32_sample    = '0;
		beep_level     = '0;
		info_sel       = 2'd1;
		seed           = 8;
		test_count     = 0;
		fail_count     = 0;
		repeat (8) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		tick();

		// Output levels right after reset
		test_errs = 0;
		if (ram_wr !== 1'b0 || mapper_reset !== 1'b0 || debug_line !== 1'b0
				|| info_req !== 1'b0 || state_menu_hidden !== 1'b1) begin
			mismatch("outputs after reset not at their idle levels");
		end
		finish_test("reset state");

		fd = $fopen("bench/shell_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open the test file bench/shell_tests.txt");
			$display("Testbench failed");
			$finish;
		end else begin
			replay_file();
			$fclose(fd);
			$display("tests run %0d, passed %0d, failed %0d",
				test_count, test_count - fail_count, fail_count);
			if (fail_count == 0) begin
				$display("Testbench passed");
			end else begin
				$display("Testbench failed");
			end
			$finish;
		end
	end

endmodule

// File: bench/shell_tests.txt
# Letter then hex fields, expected value last: R idx addr data wr ram_addr, O addr data rd,
# M cycles, D kind addr line, S addr hidden, A beep smp avail dis out, X n, I mode rom sf info, N sel n
R 00 1234 5a 1 01234
R 01 0042 c3 1 10042
R 02 0100 77 0 00000
R 00 ffff 01 1 0ffff
O 0005 a5 a5
O 07ff 3c 3c
O 0006 5a 5a
M 0f
M 0f
D 0 0000 1
D 0 0000 0
D 1 1234 1
D 1 1234 1
D 0 0000 0
S 0002 1
S 0001 0
A 000 1000 0 0 1000
A 1ff 7fff 0 0 7fff
A 0ff 7fff 1 1 7f80
A 000 8000 0 0 8000
A 001 8000 0 0 8080
A 100 8000 0 0 0000
A 001 8000 1 1 0080
X 40
I a2 00 05 06
I a2 00 0f 08
I a1 00 00 09
I a1 01 00 0a
I a1 02 00 0b
I a1 07 00 0c
I 55 00 00 0c
N 1 1
N 0 0
N 2 0

// File: sim.f
source/shell_pkg.sv
source/mt32_pkg.sv
source/ioctl_if.sv
source/mt32_if.sv
source/download_router.sv
source/reset_control.sv
source/osd_status_tracker.sv
source/audio_mixer.sv
source/mt32_info_encoder.sv
source/trs80_shell.sv
bench/trs80_shell_tb.sv

// File: Bender.yml
package:
  name: trs80_shell

sources:
  - files:
      - source/shell_pkg.sv
      - source/mt32_pkg.sv
      - source/ioctl_if.sv
      - source/mt32_if.sv
      - source/download_router.sv
      - source/reset_control.sv
      - source/osd_status_tracker.sv
      - source/audio_mixer.sv
      - source/mt32_info_encoder.sv
      - source/trs80_shell.sv
  - target: simulation
    files:
      - bench/trs80_shell_tb.sv
